// File: project.f
verilog/ipif_pkg.sv
verilog/repeating_handshake.sv
verilog/ipif_clock_converter.sv
verilog/reg_bank.sv
verilog/event_counter.sv
verilog/ipif_top.sv
verification/ipif_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

run_case() {
	name=$1
	sync=$2
	mkdir -p "build/$name"
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module ipif_tb -Gsync="$sync" --Mdir "build/$name" -o sim
	"./build/$name/sim" | tee "build/$name.log"
	if grep -q "Verification passed" "build/$name.log"; then
		echo "$name run: ok"
	else
		echo "$name run: FAILED"
		exit 1
	fi
}

run_case handshake 1
run_case bypass 0

// File: verification/ipif_tb.sv
`timescale 1ns/1ns

module ipif_tb import ipif_pkg::*; #(
	parameter int sync = 1
);

	localparam int test_count = 5;
	localparam int test_budget_ns = 4000;
	localparam int reset_cycles = 8;
	localparam int dest_period_ns = 8;
	localparam int settle_cycles = 40;
	// Only the step in bits 23..8 and the enable in bit 0 read back from control.
	localparam logic [31:0] ctrl_bits = 32'h00ff_ff01;

	logic                  dest_clk = 1'b0;
	logic                  ip_clk_free = 1'b0;
	logic                  ip_clk;
	logic                  arst_n;
	logic                  wr_en;
	logic                  rd_en;
	reg_addr_t             addr;
	logic [reg_data_w-1:0] wr_data;
	logic [reg_data_w-1:0] rd_data;

	integer      seed;
	int          error_count = 0;
	int          check_count = 0;
	string       test_name;
	logic [31:0] model_limit;
	logic [31:0] model_ctrl;
	logic [31:0] last_wraps;

	always #(dest_period_ns / 2) dest_clk = ~dest_clk;

	always begin
		#5 ip_clk_free = 1'b1;
		#6 ip_clk_free = 1'b0;
	end

	// In bypass both sides share one clock.
	assign ip_clk = (sync != 0) ? ip_clk_free : dest_clk;

	ipif_top #(
		.include_synchronizer(sync != 0)
	) dut_i (
		.dest_clk(dest_clk),
		.ip_clk  (ip_clk),
		.arst_n  (arst_n),
		.wr_en   (wr_en),
		.rd_en   (rd_en),
		.addr    (addr),
		.wr_data (wr_data),
		.rd_data (rd_data)
	);

	task automatic expect_equal(input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		assert (act === exp) else begin
			error_count++;
			$display("Fail %s: expected 0x%08h, actual 0x%08h", test_name, exp, act);
		end
	endtask

	task automatic expect_true(input bit ok, input string what);
		check_count++;
		assert (ok) else begin
			error_count++;
			$display("%s: %s", test_name, what);
		end
	endtask

	task automatic apply_reset();
		@(posedge dest_clk);
		arst_n <= 1'b0;
		repeat (reset_cycles) @(posedge dest_clk);
		arst_n <= 1'b1;
		model_limit = '0;
		model_ctrl = '0;
		last_wraps = '0;
	endtask

	// The model tracks writes to limit and control and ignores the read-only addresses.
	task automatic bus_write(input reg_addr_t a, input logic [31:0] d);
		@(posedge dest_clk);
		wr_en <= 1'b1;
		addr <= a;
		wr_data <= d;
		@(posedge dest_clk);
		wr_en <= 1'b0;
		if (a == addr_limit) begin
			model_limit = d;
		end else if (a == addr_control) begin
			model_ctrl = d & ctrl_bits;
		end
	endtask

	task automatic bus_read(input reg_addr_t a, output logic [31:0] d);
		@(posedge dest_clk);
		rd_en <= 1'b1;
		addr <= a;
		@(posedge dest_clk);
		rd_en <= 1'b0;
		@(negedge dest_clk);
		d = rd_data;
	endtask

	function automatic logic [31:0] model_read(input reg_addr_t a);
		return (a == addr_limit) ? model_limit : model_ctrl;
	endfunction

	task automatic wait_settle();
		repeat (settle_cycles) @(posedge ip_clk);
	endtask

	// Every snapshot must be a reachable counter state for the current limit and step.
	task automatic poll_counter(input int polls, input int gap);
		logic [31:0] count;
		logic [31:0] wraps;
		logic [31:0] step;
		int          i;
		step = {16'h0, model_ctrl[23:8]};
		for (i = 0; i < polls; i++) begin
			bus_read(addr_count, count);
			bus_read(addr_wraps, wraps);
			expect_true(count < model_limit,
				$sformatf("count %0d is not below the limit %0d", count, model_limit));
			expect_true(count % step == 0,
				$sformatf("count %0d is not a multiple of the step %0d", count, step));
			expect_true(wraps >= last_wraps,
				$sformatf("wraps went back from %0d to %0d", last_wraps, wraps));
			last_wraps = wraps;
			repeat (gap) @(posedge dest_clk);
		end
	endtask

	task automatic check_reset_values();
		logic [31:0] d;
		int          i;
		test_name = "reset values";
		for (i = 0; i < 4; i++) begin
			bus_read(reg_addr_t'(i), d);
			expect_equal(32'h0, d);
		end
		repeat (200) @(posedge dest_clk);
		bus_read(addr_count, d);
		expect_equal(32'h0, d);
	endtask

	task automatic check_register_access();
		logic [31:0] d;
		test_name = "register access";
		bus_write(addr_limit, 32'h1234_5678);
		bus_read(addr_limit, d);
		expect_equal(model_read(addr_limit), d);
		bus_write(addr_limit, $random(seed));
		bus_read(addr_limit, d);
		expect_equal(model_read(addr_limit), d);
		bus_write(addr_control, 32'hffff_fffe);
		bus_read(addr_control, d);
		expect_equal(model_read(addr_control), d);
		expect_true((d & ~ctrl_bits) == 0, "reserved control bits read back nonzero");
		bus_write(addr_count, 32'hdead_beef);
		bus_write(addr_wraps, 32'hcafe_f00d);
		bus_read(addr_limit, d);
		expect_equal(model_read(addr_limit), d);
		bus_read(addr_control, d);
		expect_equal(model_read(addr_control), d);
		wait_settle();
		bus_read(addr_count, d);
		expect_equal(32'h0, d);
		bus_read(addr_wraps, d);
		expect_equal(32'h0, d);
	endtask

	task automatic check_enable_control();
		logic [31:0] first;
		logic [31:0] second;
		test_name = "enable control";
		apply_reset();
		bus_write(addr_limit, 32'h0);
		bus_write(addr_control, (32'd3 << 8) | 32'd1);
		wait_settle();
		bus_read(addr_count, first);
		repeat (100) @(posedge dest_clk);
		bus_read(addr_count, second);
		expect_true(second > first, "count did not increase while enabled");
		bus_write(addr_control, 32'd3 << 8);
		wait_settle();
		bus_read(addr_count, first);
		repeat (20) @(posedge dest_clk);
		bus_read(addr_count, second);
		expect_equal(first, second);
		bus_read(addr_wraps, second);
		expect_equal(32'h0, second);
	endtask

	task automatic check_limit_wrap();
		logic [31:0] r;
		logic [31:0] lim;
		logic [31:0] stp;
		logic [31:0] wraps;
		test_name = "limit wrap";
		r = $random(seed);
		lim = 32'd1 + (r % 32'd255);
		r = $random(seed);
		stp = 32'd1 + (r % 32'd15);
		apply_reset();
		bus_write(addr_limit, lim);
		bus_write(addr_control, (stp << 8) | 32'd1);
		wait_settle();
		poll_counter(30, 8);
		wait_settle();
		bus_read(addr_wraps, wraps);
		expect_true(wraps != 0, "wraps never left zero");
	endtask

	task automatic check_consistency();
		logic [31:0] r;
		logic [31:0] stp;
		int          k;
		test_name = "snapshot consistency";
		for (k = 0; k < 2; k++) begin
			r = $random(seed);
			stp = 32'd1 + (r % 32'd15);
			apply_reset();
			bus_write(addr_limit, 32'd150);
			bus_write(addr_control, (stp << 8) | 32'd1);
			wait_settle();
			poll_counter(5, 2);
			bus_write(addr_limit, 32'd90);
			wait_settle();
			poll_counter(5, 2);
		end
	endtask

	initial begin
		arst_n = 1'b0;
		wr_en = 1'b0;
		rd_en = 1'b0;
		addr = '0;
		wr_data = '0;
		seed = 39;
		apply_reset();
		check_reset_values();
		check_register_access();
		check_enable_control();
		check_limit_wrap();
		check_consistency();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(test_count * test_budget_ns + reset_cycles * dest_period_ns);
		$display("Timeout: the tests did not finish in the allowed time");
		$display("Verification failed");
		$finish;
	end

endmodule

// File: verilog/event_counter.sv
`timescale 1ns/1ns

module event_counter import ipif_pkg::*; (
	input  logic  ip_clk,
	input  logic  arst_n,
	input  ctrl_t ctrl,
	output stat_t stat
);

	stat_word_u          stat_q;
	logic [reg_data_w:0] sum;
	logic                limit_set;
	logic                at_limit;

	// One extra bit keeps the limit compare right when the sum passes 2**32.
	assign sum = {1'b0, stat_q.fields.count} + {{(reg_data_w + 1 - step_w){1'b0}}, ctrl.step};

	assign limit_set = (ctrl.limit != '0);
	assign at_limit = limit_set && (sum >= {1'b0, ctrl.limit});

	always_ff @(posedge ip_clk or negedge arst_n) begin
		if (!arst_n) begin
			stat_q.flat <= '0;
		end else if (ctrl.enable) begin
			if (at_limit) begin
				stat_q.fields.count <= '0;
				stat_q.fields.wraps <= stat_q.fields.wraps + 1'b1;
			end else begin
				// Without a limit the count simply rolls over.
				stat_q.fields.count <= sum[reg_data_w-1:0];
			end
		end
	end

	assign stat = stat_q.fields;

endmodule

// File: verilog/ipif_clock_converter.sv
`timescale 1ns/1ns

module ipif_clock_converter import ipif_pkg::*; #(
	parameter bit include_synchronizer = 1'b1
) (
	input  logic  ip_clk,
	input  logic  dest_clk,
	input  logic  arst_n,
	input  ctrl_t ctrl_from_bus,
	input  stat_t stat_from_ip,
	output ctrl_t ctrl_to_ip,
	output stat_t stat_to_bus
);

	ctrl_word_u ctrl_src;
	ctrl_word_u ctrl_dst;
	stat_word_u stat_src;
	stat_word_u stat_dst;

	// Each word crosses as a flat vector and is read back as fields on the far side.
	assign ctrl_src.fields = ctrl_from_bus;
	assign ctrl_to_ip = ctrl_dst.fields;

	assign stat_src.fields = stat_from_ip;
	assign stat_to_bus = stat_dst.fields;

	repeating_handshake #(
		.include_synchronizer(include_synchronizer)
	) bus_to_ip (
		.src_clk  (dest_clk),
		.dest_clk (ip_clk),
		.arst_n   (arst_n),
		.src_data (ctrl_src.flat),
		.dest_data(ctrl_dst.flat)
	);

	repeating_handshake #(
		.include_synchronizer(include_synchronizer)
	) ip_to_bus (
		.src_clk  (ip_clk),
		.dest_clk (dest_clk),
		.arst_n   (arst_n),
		.src_data (stat_src.flat),
		.dest_data(stat_dst.flat)
	);

endmodule

// File: verilog/ipif_pkg.sv
package ipif_pkg;

	localparam int reg_data_w = 32;
	localparam int n_reg = 2;
	localparam int step_w = 16;

	typedef logic [1:0] reg_addr_t;

	localparam reg_addr_t addr_limit = 2'd0;
	localparam reg_addr_t addr_control = 2'd1;
	localparam reg_addr_t addr_count = 2'd2;
	localparam reg_addr_t addr_wraps = 2'd3;

	// Writable bits of the control register: step in 23..8 and enable in bit 0.
	localparam logic [reg_data_w-1:0] ctrl_write_mask = 32'h00ff_ff01;

	typedef logic [n_reg*reg_data_w-1:0] xfer_word_t;

	// The limit register sits in the upper half and the control register in the lower.
	typedef struct packed {
		logic [reg_data_w-1:0] limit;
		logic [7:0]            reserved_hi;
		logic [step_w-1:0]     step;
		logic [6:0]            reserved_lo;
		logic                  enable;
	} ctrl_t;

	typedef struct packed {
		logic [reg_data_w-1:0] count;
		logic [reg_data_w-1:0] wraps;
	} stat_t;

	typedef union packed {
		ctrl_t      fields;
		xfer_word_t flat;
	} ctrl_word_u;

	typedef union packed {
		stat_t      fields;
		xfer_word_t flat;
	} stat_word_u;

endpackage

// File: verilog/ipif_top.sv
`timescale 1ns/1ns

module ipif_top import ipif_pkg::*; #(
	parameter bit include_synchronizer = 1'b1
) (
	input  logic                  dest_clk,
	input  logic                  ip_clk,
	input  logic                  arst_n,
	input  logic                  wr_en,
	input  logic                  rd_en,
	input  reg_addr_t             addr,
	input  logic [reg_data_w-1:0] wr_data,
	output logic [reg_data_w-1:0] rd_data
);

	ctrl_t ctrl_bus;
	ctrl_t ctrl_ip;
	stat_t stat_ip;
	stat_t stat_bus;

	reg_bank reg_bank_i (
		.dest_clk(dest_clk),
		.arst_n  (arst_n),
		.wr_en   (wr_en),
		.rd_en   (rd_en),
		.addr    (addr),
		.wr_data (wr_data),
		.rd_data (rd_data),
		.stat    (stat_bus),
		.ctrl    (ctrl_bus)
	);

	// Control goes to the IP clock and status comes back to the bus clock.
	ipif_clock_converter #(
		.include_synchronizer(include_synchronizer)
	) clock_converter_i (
		.ip_clk       (ip_clk),
		.dest_clk     (dest_clk),
		.arst_n       (arst_n),
		.ctrl_from_bus(ctrl_bus),
		.stat_from_ip (stat_ip),
		.ctrl_to_ip   (ctrl_ip),
		.stat_to_bus  (stat_bus)
	);

	event_counter event_counter_i (
		.ip_clk(ip_clk),
		.arst_n(arst_n),
		.ctrl  (ctrl_ip),
		.stat  (stat_ip)
	);

endmodule

// File: verilog/reg_bank.sv
`timescale 1ns/1ns

module reg_bank import ipif_pkg::*; (
	input  logic                  dest_clk,
	input  logic                  arst_n,
	input  logic                  wr_en,
	input  logic                  rd_en,
	input  reg_addr_t             addr,
	input  logic [reg_data_w-1:0] wr_data,
	output logic [reg_data_w-1:0] rd_data,
	input  stat_t                 stat,
	output ctrl_t                 ctrl
);

	ctrl_word_u            ctrl_q;
	logic [reg_data_w-1:0] rd_next;

	assign ctrl = ctrl_q.fields;

	// Count and wrap count are read only, so writes to them fall through.
	always_ff @(posedge dest_clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_q.flat <= '0;
		end else if (wr_en) begin
			case (addr)
				addr_limit: begin
					ctrl_q.fields.limit <= wr_data;
				end
				addr_control: begin
					ctrl_q.flat[reg_data_w-1:0] <= wr_data & ctrl_write_mask;
				end
				default: begin
				end
			endcase
		end
	end

	// The control word is read back register by register from its flat view.
	always_comb begin
		case (addr)
			addr_limit: begin
				rd_next = ctrl_q.flat[reg_data_w +: reg_data_w];
			end
			addr_control: begin
				rd_next = ctrl_q.flat[0 +: reg_data_w];
			end
			addr_count: begin
				rd_next = stat.count;
			end
			addr_wraps: begin
				rd_next = stat.wraps;
			end
		endcase
	end

	// Read data is registered and kept until the next read.
	always_ff @(posedge dest_clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_data <= '0;
		end else if (rd_en) begin
			rd_data <= rd_next;
		end
	end

endmodule

// File: verilog/repeating_handshake.sv
`timescale 1ns/1ns

module repeating_handshake import ipif_pkg::*; #(
	parameter bit include_synchronizer = 1'b1
) (
	input  logic       src_clk,
	input  logic       dest_clk,
	input  logic       arst_n,
	input  xfer_word_t src_data,
	output xfer_word_t dest_data
);

	generate
		if (include_synchronizer) begin : g_handshake
			xfer_word_t hold;
			logic       req;
			logic [1:0] ack_sync;
			logic       src_ready;
			logic [1:0] req_sync;
			logic       req_seen;
			logic       req_edge;

			// The source may latch again once the acknowledge has caught up with the request.
			assign src_ready = (req == ack_sync[1]);

			always_ff @(posedge src_clk or negedge arst_n) begin
				if (!arst_n) begin
					req <= 1'b0;
					ack_sync <= 2'b00;
				end else begin
					ack_sync <= {ack_sync[0], req_seen};
					if (src_ready) begin
						req <= ~req;
					end
				end
			end

			// The hold word stays put from one latch until the destination has taken it.
			always_ff @(posedge src_clk) begin
				if (src_ready) begin
					hold <= src_data;
				end
			end

			assign req_edge = (req_sync[1] != req_seen);

			always_ff @(posedge dest_clk or negedge arst_n) begin
				if (!arst_n) begin
					req_sync <= 2'b00;
					req_seen <= 1'b0;
				end else begin
					req_sync <= {req_sync[0], req};
					req_seen <= req_sync[1];
				end
			end

			// A request edge means the hold word has been stable for at least two dest_clk cycles.
			always_ff @(posedge dest_clk or negedge arst_n) begin
				if (!arst_n) begin
					dest_data <= '0;
				end else if (req_edge) begin
					dest_data <= hold;
				end
			end
		end else begin : g_bypass
			// Both sides run on one clock, so a single stage is enough.
			always_ff @(posedge dest_clk or negedge arst_n) begin
				if (!arst_n) begin
					dest_data <= '0;
				end else begin
					dest_data <= src_data;
				end
			end
		end
	endgenerate

endmodule
